// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_top
SRC       ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_STR  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(SRC) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$($(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(SRC) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w    = 32;
    localparam int addr_w    = 12;
    localparam int reg_idx_w = 4;
    localparam int num_regs  = 16;

    localparam logic [addr_w-1:0] reset_pc = 12'd3;  // words 0 to 2 hold data

    localparam logic [2:0] stage_fetch     = 3'd0;
    localparam logic [2:0] stage_decode    = 3'd1;
    localparam logic [2:0] stage_execute   = 3'd2;
    localparam logic [2:0] stage_memory    = 3'd3;
    localparam logic [2:0] stage_writeback = 3'd4;

    localparam logic [3:0] op_nop = 4'b0000;
    localparam logic [3:0] op_ld  = 4'b0001;
    localparam logic [3:0] op_str = 4'b0010;
    localparam logic [3:0] op_bra = 4'b0011;
    localparam logic [3:0] op_xor = 4'b0100;
    localparam logic [3:0] op_add = 4'b0101;
    localparam logic [3:0] op_rot = 4'b0110;
    localparam logic [3:0] op_shf = 4'b0111;
    localparam logic [3:0] op_hlt = 4'b1000;
    localparam logic [3:0] op_cmp = 4'b1001;

    localparam logic [3:0] cond_always   = 4'd0;
    localparam logic [3:0] cond_parity   = 4'd1;
    localparam logic [3:0] cond_even     = 4'd2;
    localparam logic [3:0] cond_carry    = 4'd3;
    localparam logic [3:0] cond_negative = 4'd4;
    localparam logic [3:0] cond_zero     = 4'd5;
    localparam logic [3:0] cond_no_carry = 4'd6;
    localparam logic [3:0] cond_positive = 4'd7;

    localparam logic rw_read  = 1'b0;
    localparam logic rw_write = 1'b1;

    // one instruction word, read either as alu/memory op or as branch
    typedef union packed {
        struct packed {
            logic [3:0]        opcode;
            logic              use_imm;     // operand 1 from immediate
            logic              clear_b;     // operand 2 forced to zero
            logic [1:0]        spare;
            logic [addr_w-1:0] src_field;   // imm / load addr / src reg
            logic [addr_w-1:0] dest_field;  // store addr / dest reg
        } alu;
        struct packed {
            logic [3:0]        opcode;
            logic [3:0]        cond;
            logic [addr_w-1:0] target;
            logic [addr_w-1:0] spare;
        } bra;
    } instr_t;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [data_w-1:0] data_in,
    output logic [data_w-1:0] data_out,
    output logic [addr_w-1:0] address,
    output logic              read_write,
    output logic              mem_en,
    output logic              halted
);

    logic [2:0]           stage;
    instr_t               instr;
    logic [data_w-1:0]    result;
    logic                 branch_taken;
    logic [data_w-1:0]    store_data;
    logic [reg_idx_w-1:0] rd_a_idx;
    logic [reg_idx_w-1:0] rd_b_idx;
    logic [data_w-1:0]    rd_a_data;
    logic [data_w-1:0]    rd_b_data;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [data_w-1:0]    wr_data;

    instr_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .result       (result),
        .branch_taken (branch_taken),
        .store_data   (store_data),
        .stage        (stage),
        .instr        (instr),
        .address      (address),
        .mem_en       (mem_en),
        .read_write   (read_write),
        .data_out     (data_out),
        .halted       (halted),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data)
    );

    reg_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    exec_unit u_exec (
        .clk          (clk),
        .reset        (reset),
        .stage        (stage),
        .instr        (instr),
        .rd_a_data    (rd_a_data),
        .rd_b_data    (rd_b_data),
        .rd_a_idx     (rd_a_idx),
        .rd_b_idx     (rd_b_idx),
        .result       (result),
        .branch_taken (branch_taken),
        .store_data   (store_data)
    );

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [2:0]           stage,
    input  instr_t               instr,
    input  logic [data_w-1:0]    rd_a_data,
    input  logic [data_w-1:0]    rd_b_data,
    output logic [reg_idx_w-1:0] rd_a_idx,
    output logic [reg_idx_w-1:0] rd_b_idx,
    output logic [data_w-1:0]    result,
    output logic                 branch_taken,
    output logic [data_w-1:0]    store_data
);

    logic [data_w-1:0]   op1;
    logic [data_w-1:0]   op2;
    logic [3:0]          opcode;
    logic [3:0]          amount;
    logic [2*data_w-1:0] rot_left;
    logic [2*data_w-1:0] rot_right;
    logic [data_w:0]     shf_left;
    logic [data_w-1:0]   alu_result;
    logic                alu_carry;
    logic                carry;
    logic                zero_flag;
    logic                neg_flag;
    logic                even_flag;
    logic                parity_flag;
    logic                cond_met;

    assign opcode   = instr.alu.opcode;
    assign rd_a_idx = instr.alu.src_field[reg_idx_w-1:0];
    assign rd_b_idx = instr.alu.dest_field[reg_idx_w-1:0];

    always_ff @(posedge clk)
    begin
        if (stage == stage_decode)
        begin
            op1 <= instr.alu.use_imm ?
                   {{(data_w-addr_w){1'b0}}, instr.alu.src_field} : rd_a_data;
            op2 <= instr.alu.clear_b ? '0 : rd_b_data;
        end
    end

    assign store_data = op1;

    // rotate via doubled word, bit 4 picks direction
    assign amount    = op1[3:0];
    assign rot_left  = {op2, op2} << amount;
    assign rot_right = {op2, op2} >> amount;
    assign shf_left  = {1'b0, op2} << amount;

    always_comb
    begin
        alu_result = result;
        alu_carry  = 1'b0;
        case (opcode)
            op_nop, op_bra:
                alu_carry = carry;
            op_xor:
                alu_result = op1 ^ op2;
            op_add:
                {alu_carry, alu_result} = {1'b0, op1} + {1'b0, op2};
            op_rot:
                alu_result = op1[4] ? rot_left[2*data_w-1:data_w] : rot_right[data_w-1:0];
            op_shf:
            begin
                if (op1[4])
                    {alu_carry, alu_result} = shf_left;
                else
                    alu_result = op2 >> amount;
            end
            op_cmp:
                alu_result = ~op1 + 1'b1;  // two's complement
            default:
            begin
            end
        endcase
    end

    assign zero_flag   = (result == '0);
    assign neg_flag    = result[data_w-1];
    assign even_flag   = ~result[0];
    assign parity_flag = ^result;  // odd count of ones

    always_comb
    begin
        case (instr.bra.cond)
            cond_always:   cond_met = 1'b1;
            cond_parity:   cond_met = parity_flag;
            cond_even:     cond_met = even_flag;
            cond_carry:    cond_met = carry;
            cond_negative: cond_met = neg_flag;
            cond_zero:     cond_met = zero_flag;
            cond_no_carry: cond_met = ~carry;
            cond_positive: cond_met = ~neg_flag & ~zero_flag;
            default:       cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result       <= '0;
            carry        <= 1'b0;
            branch_taken <= 1'b0;
        end
        else if (stage == stage_execute)
        begin
            result       <= alu_result;
            carry        <= alu_carry;
            branch_taken <= (opcode == op_bra) && cond_met;  // flags from previous op
        end
    end

endmodule

// ==== instr_sequencer.sv ====
`timescale 1ns/1ps

module instr_sequencer
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [data_w-1:0]    data_in,
    input  logic [data_w-1:0]    result,
    input  logic                 branch_taken,
    input  logic [data_w-1:0]    store_data,
    output logic [2:0]           stage,
    output instr_t               instr,
    output logic [addr_w-1:0]    address,
    output logic                 mem_en,
    output logic                 read_write,
    output logic [data_w-1:0]    data_out,
    output logic                 halted,
    output logic                 wr_en,
    output logic [reg_idx_w-1:0] wr_idx,
    output logic [data_w-1:0]    wr_data
);

    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] next_pc;
    logic [data_w-1:0] load_data;
    logic [3:0]        opcode;
    logic              writes_reg;

    assign opcode  = instr.alu.opcode;
    assign next_pc = branch_taken ? instr.bra.target : pc + 1'b1;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage <= stage_fetch;
        end
        else if (!halted)  // hlt freezes in memory stage
        begin
            if (stage == stage_writeback)
                stage <= stage_fetch;
            else
                stage <= stage + 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            instr <= '0;
        else if (!halted && stage == stage_fetch)
            instr <= data_in;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc         <= reset_pc;
            address    <= reset_pc;
            mem_en     <= 1'b1;
            read_write <= rw_read;
            halted     <= 1'b0;
        end
        else if (!halted)
        begin
            case (stage)
                stage_execute:
                begin
                    case (opcode)
                        op_ld:
                        begin
                            address    <= instr.alu.src_field;
                            mem_en     <= 1'b1;
                            read_write <= rw_read;
                        end
                        op_str:
                        begin
                            address    <= instr.alu.dest_field;
                            mem_en     <= 1'b1;
                            read_write <= rw_write;  // lands at end of memory stage
                        end
                        op_hlt:
                        begin
                            mem_en <= 1'b0;
                            halted <= 1'b1;
                        end
                        default:
                        begin
                            mem_en <= 1'b0;  // no memory access
                        end
                    endcase
                end
                stage_memory:
                begin
                    pc         <= next_pc;
                    address    <= next_pc;  // set up next fetch
                    mem_en     <= 1'b1;
                    read_write <= rw_read;
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage == stage_execute && opcode == op_str)
            data_out <= store_data;
        if (stage == stage_memory && opcode == op_ld)
            load_data <= data_in;  // address still valid here
    end

    always_comb
    begin
        case (opcode)
            op_ld, op_xor, op_add, op_rot, op_shf, op_cmp:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase
    end

    assign wr_en   = (stage == stage_writeback) && writes_reg;
    assign wr_idx  = instr.alu.dest_field[reg_idx_w-1:0];
    assign wr_data = (opcode == op_ld) ? load_data : result;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [reg_idx_w-1:0] rd_a_idx,
    input  logic [reg_idx_w-1:0] rd_b_idx,
    input  logic                 wr_en,
    input  logic [reg_idx_w-1:0] wr_idx,
    input  logic [data_w-1:0]    wr_data,
    output logic [data_w-1:0]    rd_a_data,
    output logic [data_w-1:0]    rd_b_data
);

    logic [data_w-1:0] regs [num_regs];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async read ports
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

endmodule

// ==== src.f ====
cpu_pkg.sv
reg_file.sv
instr_sequencer.sv
exec_unit.sv
cpu_top.sv
tb_cpu_mem.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
    import cpu_pkg::*;
();

    logic              clk;
    logic              reset;
    logic [data_w-1:0] mem_rdata;
    logic [data_w-1:0] data_out;
    logic [addr_w-1:0] address;
    logic              read_write;
    logic              mem_en;
    logic              halted;

    logic [31:0] image [4096];  // program image, later the model's memory
    logic [11:0] load_ptr;
    logic        prog_ready = 1'b0;
    int unsigned watchdog_ns;
    logic [11:0] exp_pc [$];
    logic [3:0]  exp_op [$];
    logic [11:0] exp_addr [$];
    logic [31:0] exp_data [$];

    cpu_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .data_in    (mem_rdata),
        .data_out   (data_out),
        .address    (address),
        .read_write (read_write),
        .mem_en     (mem_en),
        .halted     (halted)
    );

    tb_cpu_mem u_mem (
        .clk        (clk),
        .address    (address),
        .mem_en     (mem_en),
        .read_write (read_write),
        .wr_data    (data_out),
        .rd_data    (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] alu_word(logic [3:0] op, logic imm, logic clr,
                                             logic [11:0] src, logic [11:0] dst);
        return {op, imm, clr, 2'b00, src, dst};
    endfunction

    function automatic logic branch_holds(logic [3:0] cond, logic [31:0] r, logic c);
        case (cond)
            cond_always:   return 1'b1;
            cond_parity:   return ^r;
            cond_even:     return !r[0];
            cond_carry:    return c;
            cond_negative: return r[31];
            cond_zero:     return r == 32'h0;
            cond_no_carry: return !c;
            cond_positive: return !r[31] && r != 32'h0;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic emit(logic [31:0] w);
        image[load_ptr] = w;
        load_ptr = load_ptr + 12'd1;
    endtask

    task automatic branch_skip(logic [3:0] cond);
        emit({op_bra, cond, load_ptr + 12'd2, 12'h000});  // taken path skips the nop
        emit(32'h0);
    endtask

    task automatic flag_branch(logic [11:0] imm, logic [3:0] cond);
        emit(alu_word(op_xor, 1'b1, 1'b1, imm, 12'd7));  // result = imm, carry clear
        branch_skip(cond);
    endtask

    task automatic neg_branch(logic [3:0] cond);
        emit(alu_word(op_cmp, 1'b1, 1'b0, 12'd1, 12'd8));  // all ones
        branch_skip(cond);
    endtask

    task automatic carry_branch(logic [3:0] cond);
        emit(alu_word(op_cmp, 1'b1, 1'b0, 12'd1, 12'd8));
        emit(alu_word(op_add, 1'b1, 1'b0, 12'd1, 12'd8));  // wraps to zero with carry
        branch_skip(cond);
    endtask

    task automatic build_program();
        logic [3:0] amt;
        for (int i = 0; i < 4096; i++)
            image[i] = {8'h00, 12'(i), 12'(i)};
        for (int i = 0; i < 3; i++)
            image[i] = $urandom;
        load_ptr = reset_pc;
        emit(alu_word(op_ld, 1'b0, 1'b0, 12'd0, 12'd1));
        emit(alu_word(op_ld, 1'b0, 1'b0, 12'd1, 12'd2));
        emit(alu_word(op_ld, 1'b0, 1'b0, 12'd2, 12'd3));
        emit(alu_word(op_xor, 1'b0, 1'b1, 12'd1, 12'd4));
        emit(alu_word(op_add, 1'b0, 1'b0, 12'd2, 12'd4));
        emit(alu_word(op_str, 1'b0, 1'b0, 12'd4, 12'h100));
        emit(alu_word(op_xor, 1'b0, 1'b0, 12'd3, 12'd4));
        emit(alu_word(op_str, 1'b0, 1'b0, 12'd4, 12'h101));
        emit(alu_word(op_cmp, 1'b0, 1'b0, 12'd4, 12'd5));
        emit(alu_word(op_str, 1'b0, 1'b0, 12'd5, 12'h102));
        for (int k = 0; k < 4; k++)
        begin
            amt = 4'($urandom);
            emit(alu_word(op_xor, 1'b0, 1'b1, 12'd1, 12'd6));
            emit(alu_word(k < 2 ? op_rot : op_shf, 1'b1, 1'b0, {7'd0, k[0], amt}, 12'd6));
            emit(alu_word(op_str, 1'b0, 1'b0, 12'd6, 12'h110 + 12'(k)));
        end
        flag_branch(12'd1, cond_parity);
        flag_branch(12'd3, cond_parity);
        flag_branch(12'd2, cond_even);
        flag_branch(12'd1, cond_even);
        carry_branch(cond_carry);
        flag_branch(12'd5, cond_carry);
        neg_branch(cond_negative);
        flag_branch(12'd1, cond_negative);
        flag_branch(12'd0, cond_zero);
        flag_branch(12'd1, cond_zero);
        flag_branch(12'd1, cond_no_carry);
        carry_branch(cond_no_carry);
        flag_branch(12'd7, cond_positive);
        flag_branch(12'd0, cond_positive);
        neg_branch(cond_positive);
        flag_branch(12'd0, cond_always);
        flag_branch(12'd0, 4'd8);  // reserved code, never taken
        emit(alu_word(op_hlt, 1'b0, 1'b0, 12'd0, 12'd0));
    endtask

    task automatic run_model();
        logic [31:0] regs [16];
        logic [31:0] w;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] res;
        logic [11:0] pc;
        logic [3:0]  op;
        logic [3:0]  amt;
        logic        c;
        logic        taken;
        logic        done;
        res = 32'h0;
        c = 1'b0;
        pc = reset_pc;
        done = 1'b0;
        for (int i = 0; i < 16; i++)
            regs[i] = 32'h0;
        while (!done)
        begin
            w = image[pc];
            op = w[31:28];
            op1 = w[27] ? {20'h0, w[23:12]} : regs[w[15:12]];
            op2 = w[26] ? 32'h0 : regs[w[3:0]];
            amt = op1[3:0];
            taken = (op == op_bra) && branch_holds(w[27:24], res, c);
            exp_pc.push_back(pc);
            exp_op.push_back(op);
            exp_addr.push_back(op == op_ld ? w[23:12] : w[11:0]);
            exp_data.push_back(op1);
            case (op)
                op_xor: {c, res} = {1'b0, op1 ^ op2};
                op_add: {c, res} = {1'b0, op1} + {1'b0, op2};
                op_rot: {c, res} = op1[4] ?
                    {1'b0, (op2 << amt) | (op2 >> (6'd32 - {2'b00, amt}))} :
                    {1'b0, (op2 >> amt) | (op2 << (6'd32 - {2'b00, amt}))};
                op_shf: {c, res} = op1[4] ? {1'b0, op2} << amt : {1'b0, op2 >> amt};
                op_cmp: {c, res} = {1'b0, 32'h0 - op1};
                op_nop, op_bra:
                begin
                end
                default: c = 1'b0;  // ld, str, hlt keep result
            endcase
            if (op == op_ld)
                regs[w[3:0]] = image[w[23:12]];
            else if (op inside {op_xor, op_add, op_rot, op_shf, op_cmp})
                regs[w[3:0]] = res;
            if (op == op_str)
                image[w[11:0]] = op1;
            done = (op == op_hlt);
            pc = taken ? w[23:12] : pc + 12'd1;
        end
    endtask

    task automatic check_cycle(int i, int k);
        logic [3:0] op;
        op = exp_op[i];
        if (k == 0)
        begin
            check_value("address", 32'(address), 32'(exp_pc[i]));
            assert (mem_en && read_write == rw_read && !halted)
            else report_error("fetch cycle without a memory read");
        end
        else if (k >= 3 && op == op_hlt)
        begin
            assert (halted && !mem_en)
            else report_error("HLT did not stop the processor");
        end
        else if (k == 3 && (op == op_ld || op == op_str))
        begin
            check_value("address", 32'(address), 32'(exp_addr[i]));
            check_value("mem_en", 32'(mem_en), 32'd1);
            check_value("read_write", 32'(read_write), (op == op_str) ? 32'd1 : 32'd0);
            if (op == op_str)
                check_value("data_out", data_out, exp_data[i]);
        end
        else
        begin
            assert (!(mem_en && read_write == rw_write))
            else report_error("memory write outside a store's memory stage");
        end
    endtask

    initial
    begin
        wait (prog_ready);
        #(watchdog_ns);
        report_error("watchdog expired before the program reached HLT");
    end

    initial
    begin
        reset = 1'b1;
        void'($urandom(32'hb76f));
        build_program();
        for (int i = 0; i < 4096; i++)
            u_mem.mem[i] = image[i];
        run_model();
        watchdog_ns = 2 * exp_pc.size() * 5 * 4;
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (exp_pc[i])
        begin
            for (int k = 0; k < 5; k++)
            begin
                @(negedge clk);
                check_cycle(i, k);
            end
        end
        repeat (20)
        begin
            @(negedge clk);
            assert (halted && !mem_en)
            else report_error("processor left the halted state");
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tb_cpu_mem.sv ====
`timescale 1ns/1ps

module tb_cpu_mem
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic [addr_w-1:0] address,
    input  logic              mem_en,
    input  logic              read_write,
    input  logic [data_w-1:0] wr_data,
    output logic [data_w-1:0] rd_data
);

    logic [data_w-1:0] mem [2**addr_w];  // loaded by the testbench before reset ends

    always @(posedge clk)
    begin
        if (mem_en && read_write == rw_write)
        begin
            mem[address] <= wr_data;
        end
    end

    assign rd_data = mem[address];  // async read

endmodule
